/* logic/rom_fetch_pkg.sv */
// rom fetch shared definitions
package rom_fetch_pkg;

    // sdram address width, the address counts 16-bit halfwords
    localparam int MEM_AW = 22;

    // one sdram read returns a full 32-bit word, i.e. two halfwords
    localparam int WORD_W = 32;

    // address as it appears on the sdram read port
    typedef logic [MEM_AW-1:0] mem_addr_t;

    // one memory word as returned by the response channel
    typedef logic [WORD_W-1:0] mem_word_t;

    // arbiter states
    // idle waits for a miss from either requester,
    // issue holds the read request until memory takes it,
    // wait holds until the single outstanding response returns
    typedef enum logic [1:0] {
        ARB_IDLE  = 2'd0,  // no read in flight
        ARB_ISSUE = 2'd1,  // mem_req_valid high, waiting for ready
        ARB_WAIT  = 2'd2   // request accepted, waiting for mem_rsp_valid
    } arb_state_t;

endpackage

/* logic/rom_requester.sv */
`timescale 1ns/100ps
// rom client requester with two-word cache
module rom_requester #(
    parameter int                       AW     = 16,  // client address width
    parameter int                       DW     = 8,   // client data width, 8, 16 or 32
    parameter rom_fetch_pkg::mem_addr_t OFFSET = '0   // region base in sdram
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     flush,    // drops both cache entries
    input  logic [AW-1:0]            addr,
    input  logic                     addr_ok,  // addr holds a valid request
    input  rom_fetch_pkg::mem_word_t din,
    input  logic                     din_ok,
    input  logic                     we,       // this response belongs to us
    output logic                     req,
    output logic                     data_ok,  // one-cycle strobe, dout is good
    output rom_fetch_pkg::mem_addr_t mem_addr,
    output logic [DW-1:0]            dout
);
    import rom_fetch_pkg::*;

    // number of client address bits that pick a unit inside one word
    localparam int SUB_W = (DW == 8) ? 2 : ((DW == 16) ? 1 : 0);

    // clears the sub-word bits so every unit of a word shares one tag
    localparam logic [AW-1:0] ALIGN_MASK = ~AW'((1 << SUB_W) - 1);

    logic [AW-1:0] addr_al;   // client address aligned to the word
    mem_addr_t     addr_ext;  // aligned address widened to sdram width
    logic [AW-1:0] tag0;      // newest entry
    logic [AW-1:0] tag1;      // older entry
    mem_word_t     data0;
    mem_word_t     data1;
    logic [1:0]    valid;     // bit 0 for entry 0, bit 1 for entry 1
    logic          hit0;
    logic          hit1;
    logic          passthru;  // fresh response for this client this cycle
    mem_word_t     data_mux;  // word that feeds the unit selector

    // only the three supported widths make sense for the selector below
    if (!(DW == 8 || DW == 16 || DW == 32)) begin : g_bad_dw
        $error("rom_requester supports DW of 8, 16 or 32 only");
    end

    assign addr_al  = addr & ALIGN_MASK;
    assign addr_ext = mem_addr_t'(addr_al);

    // byte clients count bytes, so two of them share one sdram halfword address
    assign mem_addr = ((DW == 8) ? (addr_ext >> 1) : addr_ext) + OFFSET;

    assign hit0     = valid[0] && (addr_al == tag0);
    assign hit1     = valid[1] && (addr_al == tag1);
    assign passthru = din_ok && we;

    // a miss asks at once, but not while our own response is landing
    // flush also asks so the arbiter refills the current address
    assign req = flush || (addr_ok && !(hit0 || hit1) && !we);

    // control state, the strobe follows a hit or a fresh word by one edge
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid   <= 2'b00;
            data_ok <= 1'b0;
        end else begin
            data_ok <= addr_ok && (hit0 || hit1 || passthru);
            if (flush) begin
                valid <= 2'b00;               // flush wins over a landing word
            end else if (passthru) begin
                valid <= {valid[0], 1'b1};    // old entry 0 validity moves up
            end
        end
    end

    // cache payload, a new word pushes entry 0 down into entry 1
    always_ff @(posedge clk) begin
        if (passthru) begin
            tag1  <= tag0;
            data1 <= data0;
            tag0  <= addr_al;  // client keeps addr stable until data_ok
            data0 <= din;
        end
    end

    // a fresh word goes straight to the selector and saves one cycle
    // once written, entry 0 holds it and hit0 keeps dout steady
    assign data_mux = passthru ? din : (hit0 ? data0 : data1);

    if (DW == 8) begin : g_byte
        always_comb begin
            dout = data_mux[{addr[1:0], 3'b000} +: 8];  // byte k is bits 8k+7:8k
        end
    end else if (DW == 16) begin : g_half
        always_comb begin
            dout = data_mux[{addr[0], 4'b0000} +: 16];  // low half when addr[0] is 0
        end
    end else begin : g_word
        always_comb begin
            dout = data_mux;
        end
    end

    // data only ever answers a request that was standing on the previous cycle
    a_data_ok_needs_addr_ok: assert property (
        @(posedge clk) disable iff (rst)
        data_ok |-> $past(addr_ok)
    ) else $error("data_ok without addr_ok on the previous cycle");

endmodule

/* logic/rom_arbiter.sv */
`timescale 1ns/100ps
// round-robin sdram read arbiter
module rom_arbiter (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      req0,
    input  logic                      req1,
    input  rom_fetch_pkg::mem_addr_t  mem_addr0,
    input  rom_fetch_pkg::mem_addr_t  mem_addr1,
    output logic                      we0,           // response is for client 0
    output logic                      we1,           // response is for client 1
    output rom_fetch_pkg::mem_word_t  din,           // shared by both requesters
    output logic                      din_ok,
    output logic                      mem_req_valid,
    input  logic                      mem_req_ready,
    output rom_fetch_pkg::mem_addr_t  mem_req_addr,
    input  logic                      mem_rsp_valid,
    input  rom_fetch_pkg::mem_word_t  mem_rsp_data
);
    import rom_fetch_pkg::*;

    arb_state_t state;
    logic       owner;     // client of the read in flight, 1 means client 1
    logic       last1;     // client 1 was the last one served
    logic       pick1;     // grant decision taken in ARB_IDLE
    mem_addr_t  addr_q;    // address latched at grant time
    logic       rsp_take;  // response arrives for the read in flight

    // client 1 wins when it asks alone, or when both ask and client 0 went last
    assign pick1 = req1 && (!req0 || !last1);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= ARB_IDLE;
            owner <= 1'b0;
            last1 <= 1'b1;  // client 0 gets the first turn
        end else begin
            case (state)
                ARB_IDLE: begin
                    if (req0 || req1) begin
                        owner <= pick1;
                        state <= ARB_ISSUE;
                    end
                end
                ARB_ISSUE: begin
                    if (mem_req_ready) begin
                        state <= ARB_WAIT;  // request taken this cycle
                    end
                end
                ARB_WAIT: begin
                    if (mem_rsp_valid) begin
                        last1 <= owner;     // the other client goes first next time
                        state <= ARB_IDLE;
                    end
                end
                default: begin
                    state <= ARB_IDLE;
                end
            endcase
        end
    end

    // the address is payload and only changes on a grant
    always_ff @(posedge clk) begin
        if (state == ARB_IDLE && (req0 || req1)) begin
            addr_q <= pick1 ? mem_addr1 : mem_addr0;
        end
    end

    assign mem_req_valid = (state == ARB_ISSUE);
    assign mem_req_addr  = addr_q;  // held through back-pressure

    // only one read is outstanding, so a valid response in ARB_WAIT is ours
    assign rsp_take = (state == ARB_WAIT) && mem_rsp_valid;
    assign din      = mem_rsp_data;
    assign din_ok   = rsp_take;
    assign we0      = rsp_take && !owner;
    assign we1      = rsp_take && owner;

    // memory may stall the request but never sees it move underneath
    a_req_addr_stable: assert property (
        @(posedge clk) disable iff (rst)
        (mem_req_valid && !mem_req_ready) |=> (mem_req_valid && $stable(mem_req_addr))
    ) else $error("memory request dropped or changed under back-pressure");

    // a response word lands in exactly one cache
    a_we_onehot: assert property (
        @(posedge clk) disable iff (rst)
        !(we0 && we1)
    ) else $error("response routed to both clients");

    // the memory side answers only an accepted request
    a_rsp_in_wait: assert property (
        @(posedge clk) disable iff (rst)
        mem_rsp_valid |-> (state == ARB_WAIT)
    ) else $error("memory response with no read outstanding");

endmodule

/* logic/rom_fetch_top.sv */
`timescale 1ns/100ps
// two-client rom fetch top
module rom_fetch_top #(
    parameter int                       AW0     = 16,        // byte client address
    parameter int                       DW0     = 8,
    parameter rom_fetch_pkg::mem_addr_t OFFSET0 = 22'h00000,
    parameter int                       AW1     = 17,        // halfword client address
    parameter int                       DW1     = 16,
    parameter rom_fetch_pkg::mem_addr_t OFFSET1 = 22'h10000  // second rom region
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      flush,
    input  logic [AW0-1:0]            addr0,
    input  logic                      addr_ok0,
    input  logic [AW1-1:0]            addr1,
    input  logic                      addr_ok1,
    output logic [DW0-1:0]            dout0,
    output logic                      data_ok0,
    output logic [DW1-1:0]            dout1,
    output logic                      data_ok1,
    output logic                      mem_req_valid,
    input  logic                      mem_req_ready,
    output rom_fetch_pkg::mem_addr_t  mem_req_addr,
    input  logic                      mem_rsp_valid,
    input  rom_fetch_pkg::mem_word_t  mem_rsp_data
);
    import rom_fetch_pkg::*;

    logic      req0;
    logic      req1;
    mem_addr_t mem_addr0;  // sdram address wanted by client 0
    mem_addr_t mem_addr1;
    logic      we0;
    logic      we1;
    mem_word_t din;        // response word, common to both caches
    logic      din_ok;

    rom_requester #(
        .AW     (AW0),
        .DW     (DW0),
        .OFFSET (OFFSET0)
    ) u_req0 (
        .clk      (clk),
        .rst      (rst),
        .flush    (flush),
        .addr     (addr0),
        .addr_ok  (addr_ok0),
        .din      (din),
        .din_ok   (din_ok),
        .we       (we0),
        .req      (req0),
        .data_ok  (data_ok0),
        .mem_addr (mem_addr0),
        .dout     (dout0)
    );

    rom_requester #(
        .AW     (AW1),
        .DW     (DW1),
        .OFFSET (OFFSET1)
    ) u_req1 (
        .clk      (clk),
        .rst      (rst),
        .flush    (flush),
        .addr     (addr1),
        .addr_ok  (addr_ok1),
        .din      (din),
        .din_ok   (din_ok),
        .we       (we1),
        .req      (req1),
        .data_ok  (data_ok1),
        .mem_addr (mem_addr1),
        .dout     (dout1)
    );

    // single read port, one client served at a time
    rom_arbiter u_arb (
        .clk           (clk),
        .rst           (rst),
        .req0          (req0),
        .req1          (req1),
        .mem_addr0     (mem_addr0),
        .mem_addr1     (mem_addr1),
        .we0           (we0),
        .we1           (we1),
        .din           (din),
        .din_ok        (din_ok),
        .mem_req_valid (mem_req_valid),
        .mem_req_ready (mem_req_ready),
        .mem_req_addr  (mem_req_addr),
        .mem_rsp_valid (mem_rsp_valid),
        .mem_rsp_data  (mem_rsp_data)
    );

endmodule

/* verification/tb_clock_gen.sv */
`timescale 1ns/100ps
// testbench clock and reset
module tb_clock_gen #(
    parameter int PERIOD_NS    = 20,  // full clock period
    parameter int RESET_CYCLES = 2    // rising edges seen while rst is high
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // reset is released just after an edge, the same way the stimulus moves
    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;
    end

endmodule

/* verification/rom_fetch_tb.sv */
`timescale 1ns/100ps
// rom fetch subsystem testbench
module rom_fetch_tb;
    import rom_fetch_pkg::*;

    localparam int        CLK_PERIOD_NS   = 20;
    localparam mem_addr_t OFFSET0         = 22'h00000;  // byte client region
    localparam mem_addr_t OFFSET1         = 22'h10000;  // halfword client region
    localparam int        N_RAND          = 40;         // random reads per client
    localparam int        N_CONC          = 30;         // reads per client that run in parallel
    localparam int        N_READS         = 2 * N_RAND + 4 + 7 + 3 + 2 * N_CONC;
    localparam int        CYCLES_PER_READ = 40;         // other client's read plus stalls
    localparam int        WATCHDOG_NS     = (N_READS * CYCLES_PER_READ + 50) * CLK_PERIOD_NS;

    logic        clk;
    logic        rst;
    logic        flush;
    logic [15:0] addr0;
    logic        addr_ok0;
    logic [16:0] addr1;
    logic        addr_ok1;
    logic [7:0]  dout0;
    logic        data_ok0;
    logic [15:0] dout1;
    logic        data_ok1;
    logic        mem_req_valid;
    logic        mem_req_ready;
    mem_addr_t   mem_req_addr;
    logic        mem_rsp_valid;
    mem_word_t   mem_rsp_data;

    integer      mem_seed  = 32'h11c3;  // memory latency and back-pressure
    integer      stim_seed = 32'h11c3;  // client addresses
    int          acc_count = 0;         // requests accepted at the memory port
    int          rsp_count = 0;
    int          miss_total = 0;        // misses predicted by the cache model
    mem_addr_t   last_acc_addr;
    logic [15:0] exp_q0 [$];            // expected data with one entry per open read
    logic [15:0] exp_q1 [$];
    string       name_q0 [$];
    string       name_q1 [$];
    mem_addr_t   model_tag [2][2];      // indexed by client and entry, entry 0 is the newest
    bit          model_vld [2][2];
    logic [16:0] conc0 [N_CONC];
    logic [16:0] conc1 [N_CONC];

    tb_clock_gen #(.PERIOD_NS(CLK_PERIOD_NS), .RESET_CYCLES(2)) u_clk (.clk(clk), .rst(rst));

    rom_fetch_top #(
        .AW0(16), .DW0(8), .OFFSET0(OFFSET0),
        .AW1(17), .DW1(16), .OFFSET1(OFFSET1)
    ) u_dut (
        .clk(clk), .rst(rst), .flush(flush),
        .addr0(addr0), .addr_ok0(addr_ok0), .addr1(addr1), .addr_ok1(addr_ok1),
        .dout0(dout0), .data_ok0(data_ok0), .dout1(dout1), .data_ok1(data_ok1),
        .mem_req_valid(mem_req_valid), .mem_req_ready(mem_req_ready),
        .mem_req_addr(mem_req_addr), .mem_rsp_valid(mem_rsp_valid),
        .mem_rsp_data(mem_rsp_data)
    );

    // rom contents are a fixed scramble of the sdram address
    function automatic mem_word_t mem_word(input mem_addr_t a);
        logic [31:0] x;
        x = {10'd0, a} * 32'h9e37_79b1;
        return x ^ {a[9:0], a} ^ 32'h0bad_c0de;
    endfunction

    // sdram address of the word holding a client address
    function automatic mem_addr_t word_addr(input int client, input logic [16:0] addr);
        mem_addr_t aligned;
        if (client == 0) begin
            aligned = mem_addr_t'(addr[15:0] & 16'hfffc);  // byte client counts bytes
            return (aligned >> 1) + OFFSET0;
        end
        aligned = mem_addr_t'(addr & 17'h1fffe);
        return aligned + OFFSET1;
    endfunction

    // expected client data is zero extended to 16 bits for the byte client
    function automatic logic [15:0] expect_data(input int client, input logic [16:0] addr);
        mem_word_t   w;
        logic [15:0] r;
        w = mem_word(word_addr(client, addr));
        if (client == 1) begin
            r = addr[0] ? w[31:16] : w[15:0];
        end else begin
            case (addr[1:0])
                2'd0: r = {8'h00, w[7:0]};
                2'd1: r = {8'h00, w[15:8]};
                2'd2: r = {8'h00, w[23:16]};
                default: r = {8'h00, w[31:24]};
            endcase
        end
        return r;
    endfunction

    function automatic bit model_hit(input int c, input mem_addr_t wa);
        return (model_vld[c][0] && model_tag[c][0] == wa) ||
               (model_vld[c][1] && model_tag[c][1] == wa);
    endfunction

    // a new word pushes the newest entry down and the oldest one out
    task automatic model_fill(input int c, input mem_addr_t wa);
        model_tag[c][1] = model_tag[c][0];
        model_vld[c][1] = model_vld[c][0];
        model_tag[c][0] = wa;
        model_vld[c][0] = 1'b1;
    endtask

    task automatic model_clear();
        for (int c = 0; c < 2; c++) begin
            model_vld[c][0] = 1'b0;
            model_vld[c][1] = 1'b0;
        end
    endtask

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("TEST FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            stop_run($sformatf("FAIL %s expected %0h actual %0h", name, expected, actual));
        end
    endtask

    // every stimulus change lands 1 ns after a rising edge
    task automatic next_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    // one client read from addr_ok up to the end of the data_ok pulse
    task automatic client_read(input int client, input logic [16:0] addr,
                               input string name, input bit check_cost);
        mem_addr_t wa;
        bit        miss;
        int        start_cnt;
        int        cycles;
        bit        dok;
        wa = word_addr(client, addr);
        miss = !model_hit(client, wa);
        if (miss) begin
            model_fill(client, wa);  // the fetched word becomes the newest entry
            miss_total++;
        end
        start_cnt = acc_count;
        cycles = 0;
        if (client == 0) begin
            exp_q0.push_back(expect_data(0, addr));
            name_q0.push_back(name);
            addr0 = addr[15:0];
            addr_ok0 = 1'b1;
        end else begin
            exp_q1.push_back(expect_data(1, addr));
            name_q1.push_back(name);
            addr1 = addr;
            addr_ok1 = 1'b1;
        end
        do begin
            next_cycles(1);
            cycles++;
            dok = (client == 0) ? data_ok0 : data_ok1;
        end while (!dok);
        // drop the request in the strobe cycle, addr stays until the next read
        if (client == 0) begin
            addr_ok0 = 1'b0;
        end else begin
            addr_ok1 = 1'b0;
        end
        if (!miss) check_value({name, " hit latency"}, 1, 32'(cycles));
        if (check_cost) begin
            check_value({name, " memory requests"}, 32'(miss), 32'(acc_count - start_cnt));
        end
        next_cycles(1);
        dok = (client == 0) ? data_ok0 : data_ok1;
        check_value({name, " data_ok pulse"}, 0, 32'(dok));  // one cycle wide
    endtask

    // compares dout against the oldest open read while data_ok is high
    always @(negedge clk) begin
        if (data_ok0) begin
            if (exp_q0.size() == 0) stop_run("data_ok0 pulsed with no read outstanding");
            else check_value(name_q0.pop_front(), 32'(exp_q0.pop_front()), 32'(dout0));
        end
        if (data_ok1) begin
            if (exp_q1.size() == 0) stop_run("data_ok1 pulsed with no read outstanding");
            else check_value(name_q1.pop_front(), 32'(exp_q1.pop_front()), 32'(dout1));
        end
    end

    // sdram model that answers each accepted read 1 to 4 cycles later
    initial begin
        int        delay;
        bit        pending;
        mem_addr_t pend_addr;
        pending = 1'b0;
        delay = 0;
        mem_req_ready = 1'b0;
        mem_rsp_valid = 1'b0;
        mem_rsp_data = '0;
        wait (rst === 1'b0);
        forever begin
            @(posedge clk);
            #1;
            mem_rsp_valid = 1'b0;
            if (pending && delay == 0) begin
                mem_rsp_valid = 1'b1;
                mem_rsp_data = mem_word(pend_addr);
                pending = 1'b0;
                rsp_count++;
            end else if (pending) begin
                delay--;
            end
            mem_req_ready = (($random(mem_seed) & 3) != 0);  // stalls about one cycle in four
            @(negedge clk);
            if (mem_req_valid && mem_req_ready) begin
                if (pending) stop_run("second memory read accepted while one is outstanding");
                pending = 1'b1;
                pend_addr = mem_req_addr;
                last_acc_addr = mem_req_addr;
                delay = $random(mem_seed) & 3;
                acc_count++;
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        stop_run("watchdog expired, the run timed out");
    end

    initial begin
        logic [16:0] a;
        logic [16:0] b;
        logic [16:0] last_a1;
        int          base_cnt;
        int          base_rsp;
        int          base_miss;
        flush = 1'b0;
        addr0 = '0;
        addr_ok0 = 1'b0;
        addr1 = '0;
        addr_ok1 = 1'b0;
        model_clear();
        last_a1 = '0;
        wait (rst === 1'b0);
        next_cycles(1);

        // random bytes stay below 0x8000 so words at 0x8000 and up are free for later tests
        for (int i = 0; i < N_RAND; i++) begin
            a = 17'($random(stim_seed)) & 17'h07fff;
            client_read(0, a, "byte_random", 1'b1);
        end
        for (int i = 0; i < N_RAND; i++) begin
            last_a1 = 17'($random(stim_seed)) & 17'h0ffff;
            client_read(1, last_a1, "half_random", 1'b1);
        end

        // the other three bytes of a fetched word come from the cache
        base_cnt = acc_count;
        for (int i = 0; i < 4; i++) begin
            client_read(0, 17'h0a440 + 17'(i), "same_word", 1'b1);
        end
        check_value("same_word total requests", 1, 32'(acc_count - base_cnt));

        // words A, B and C sit at 0xc000, 0xc104 and 0xc208 and C evicts A
        base_cnt = acc_count;
        client_read(0, 17'h0c001, "alternate", 1'b1);
        client_read(0, 17'h0c106, "alternate", 1'b1);
        client_read(0, 17'h0c003, "alternate", 1'b1);
        client_read(0, 17'h0c104, "alternate", 1'b1);
        client_read(0, 17'h0c002, "alternate", 1'b1);
        client_read(0, 17'h0c209, "alternate", 1'b1);
        client_read(0, 17'h0c000, "alternate", 1'b1);
        check_value("alternate total requests", 4, 32'(acc_count - base_cnt));

        // park both clients on other words, flush refills one parked word
        addr0 = 16'he000;
        addr1 = last_a1 ^ 17'h10000;
        base_cnt = acc_count;
        base_rsp = rsp_count;
        flush = 1'b1;
        next_cycles(1);
        flush = 1'b0;
        model_clear();
        while (rsp_count == base_rsp) begin
            @(negedge clk);  // the response count moves 1 ns after a rising edge
        end
        next_cycles(2);
        check_value("flush refill requests", 1, 32'(acc_count - base_cnt));
        if (last_acc_addr == word_addr(0, {1'b0, addr0})) model_fill(0, last_acc_addr);
        else if (last_acc_addr == word_addr(1, addr1)) model_fill(1, last_acc_addr);
        else stop_run("flush refill read an address that no client holds");
        client_read(0, 17'h0c001, "flush_c0", 1'b1);
        client_read(1, last_a1, "flush_c1", 1'b1);

        // both clients run at once on four words each so the cache gets hits
        for (int i = 0; i < N_CONC; i++) begin
            a = 17'($random(stim_seed));
            b = 17'($random(stim_seed));
            conc0[i] = {13'h0030, a[3:0]};
            conc1[i] = {14'h0100, b[2:0]};
        end
        base_cnt = acc_count;
        base_miss = miss_total;
        fork
            for (int i = 0; i < N_CONC; i++) begin
                client_read(0, conc0[i], "concurrent_c0", 1'b0);
            end
            for (int i = 0; i < N_CONC; i++) begin
                client_read(1, conc1[i], "concurrent_c1", 1'b0);
            end
        join
        check_value("concurrent requests", 32'(miss_total - base_miss),
                    32'(acc_count - base_cnt));

        $display("TEST OK");
        $finish;
    end

endmodule

/* vlog.f */
logic/rom_fetch_pkg.sv
logic/rom_requester.sv
logic/rom_arbiter.sv
logic/rom_fetch_top.sv
verification/tb_clock_gen.sv
verification/rom_fetch_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the rom fetch testbench with verilator, run it and check the log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert -f vlog.f --top-module rom_fetch_tb \
    -o rom_fetch_sim > build.log 2>&1 \
    || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/rom_fetch_sim > sim.log 2>&1 \
    || echo "simulator exited with an error status" >> sim.log

cat sim.log

grep -qx "TEST OK" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
